/* Makefile */
# Verilator build and run of the graphics testbench
SIM = obj_dir/graphics_sim

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --assert -j 0 --top-module graphics_tb -o graphics_sim -f all.f
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+hw
hw/game_pkg.sv
hw/video_pkg.sv
hw/xvga_timing.sv
hw/player_blob.sv
hw/grid_renderer.sv
hw/graphics.sv
hw/graphics_top.sv
sim/graphics_tb.sv

/* hw/game_pkg.sv */
`include "graphics_macros.svh"

package game_pkg;

   // what a player holds or does, picks the sprite colour
   typedef enum logic [3:0] {
      ST_NOTHING       = 4'd0,
      ST_CHOPPING      = 4'd1,
      ST_ONION_WHOLE   = 4'd2,
      ST_ONION_CHOPPED = 4'd3,
      ST_POT_EMPTY     = 4'd4,
      ST_POT_SOUP      = 4'd5,
      ST_BOWL_EMPTY    = 4'd6,
      ST_BOWL_FULL     = 4'd7,
      ST_EXT_OFF       = 4'd8,
      ST_EXT_ON        = 4'd9
   } player_state_t;

   typedef enum logic [1:0] {
      DIR_LEFT  = 2'd0,
      DIR_RIGHT = 2'd1,
      DIR_UP    = 2'd2,
      DIR_DOWN  = 2'd3
   } direction_t;

   // contents of one kitchen cell
   typedef enum logic [3:0] {
      OBJ_EMPTY         = 4'd0,
      OBJ_ONION_WHOLE   = 4'd1,
      OBJ_ONION_CHOPPED = 4'd2,
      OBJ_BOWL_EMPTY    = 4'd3,
      OBJ_BOWL_FULL     = 4'd4,
      OBJ_POT_EMPTY     = 4'd5,
      OBJ_POT_RAW       = 4'd6,
      OBJ_POT_COOKED    = 4'd7,
      OBJ_POT_FIRE      = 4'd8,
      OBJ_FIRE          = 4'd9,
      OBJ_EXTINGUISHER  = 4'd10
   } grid_obj_t;

   // x and y are the screen position of the box's top-left corner
   typedef struct packed {
      logic [8:0]    x;
      logic [8:0]    y;
      direction_t    direction;
      player_state_t state;
   } player_t;

   typedef enum logic [2:0] {
      MODE_WELCOME = 3'd0,
      MODE_PLAY    = 3'd1,
      MODE_OVER    = 3'd2
   } game_mode_t;

   // indexed [column][row]
   typedef grid_obj_t [`GRID_COLS-1:0][`GRID_ROWS-1:0] object_grid_t;

endpackage

/* hw/graphics.sv */
module graphics (
   input  logic                    clock,
   input  logic                    rst_n,
   input  video_pkg::raster_t      raster,
   input  game_pkg::player_t [3:0] players,
   input  logic [1:0]              num_players,
   input  game_pkg::game_mode_t    mode,
   input  game_pkg::object_grid_t  object_grid,
   output video_pkg::pixel_u       pixel,
   output logic                    hsync,
   output logic                    vsync,
   output logic                    blank
);
   import game_pkg::*;
   import video_pkg::*;

   localparam int NUM_BLOBS = 4;

   pixel_u [NUM_BLOBS-1:0] blob_pixel;
   pixel_u                 tile_pixel;
   logic                   hsync_d;
   logic                   vsync_d;
   logic                   blank_d;
   logic [6:0]             sum_r;
   logic [6:0]             sum_g;
   logic [6:0]             sum_b;
   pixel_u                 mixed;
   pixel_u                 pixel_next;

   // clamp a five-way channel sum to 4 bits
   function automatic logic [3:0] sat4(input logic [6:0] sum);
      return (sum > 7'd15) ? 4'hF : sum[3:0];
   endfunction

   // stage 1, sprite layers; num_players n enables players 0..n
   for (genvar i = 0; i < NUM_BLOBS; i++) begin : g_blob
      player_blob blob (
         .clock  (clock),
         .rst_n  (rst_n),
         .raster (raster),
         .player (players[i]),
         .enable (2'(i) <= num_players),
         .pixel  (blob_pixel[i])
      );
   end

   // stage 1, tile layer
   grid_renderer grid (
      .clock       (clock),
      .rst_n       (rst_n),
      .raster      (raster),
      .object_grid (object_grid),
      .pixel       (tile_pixel)
   );

   // syncs and blank follow the layers by one register
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         hsync_d <= 1'b1;
         vsync_d <= 1'b1;
         blank_d <= 1'b1;
      end else begin
         hsync_d <= raster.hsync;
         vsync_d <= raster.vsync;
         blank_d <= raster.blank;
      end
   end

   // stage 2 mix, per channel with saturation
   always_comb begin
      sum_r = 7'(tile_pixel.rgb.r);
      sum_g = 7'(tile_pixel.rgb.g);
      sum_b = 7'(tile_pixel.rgb.b);
      for (int k = 0; k < NUM_BLOBS; k++) begin
         sum_r = sum_r + 7'(blob_pixel[k].rgb.r);
         sum_g = sum_g + 7'(blob_pixel[k].rgb.g);
         sum_b = sum_b + 7'(blob_pixel[k].rgb.b);
      end
      mixed.rgb.r = sat4(sum_r);
      mixed.rgb.g = sat4(sum_g);
      mixed.rgb.b = sat4(sum_b);

      // blank wins, then the welcome/over screen, then the game
      if (blank_d) begin
         pixel_next = '0;
      end else if (mode != MODE_PLAY) begin
         pixel_next = WELCOME_COLOR;
      end else begin
         pixel_next = mixed;
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         pixel <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
         blank <= 1'b1;
      end else begin
         pixel <= pixel_next;
         hsync <= hsync_d;
         vsync <= vsync_d;
         blank <= blank_d;
      end
   end

   // nothing may reach the display during blanking
   a_blank_black: assert property (@(posedge clock) disable iff (!rst_n)
      blank |-> (pixel.raw == 12'h000));

endmodule

/* hw/graphics_macros.svh */
`ifndef GRAPHICS_MACROS_SVH
`define GRAPHICS_MACROS_SVH

// xvga 1024x768 frame, counted in pixel clocks and lines
`define FRAME_H_TOTAL 1344
`define FRAME_V_TOTAL 806
`define ACTIVE_W      1024
`define ACTIVE_H      768

// sync windows, end is exclusive
`define H_SYNC_START  1048
`define H_SYNC_END    1184
`define V_SYNC_START  771
`define V_SYNC_END    777

// kitchen grid placement on screen
`define GRID_X0       112
`define GRID_Y0       112
`define TILE_SIZE     32
`define GRID_COLS     8
`define GRID_ROWS     13

// player box and facing marker
`define BLOB_SIZE     32
`define MARKER_SIZE   4

`endif

/* hw/graphics_top.sv */
module graphics_top (
   input  logic                    clock,
   input  logic                    rst_n,
   input  game_pkg::player_t [3:0] players,
   input  logic [1:0]              num_players,
   input  game_pkg::game_mode_t    mode,
   input  game_pkg::object_grid_t  object_grid,
   output logic [11:0]             pixel,
   output logic                    hsync,
   output logic                    vsync,
   output logic                    blank
);
   import video_pkg::*;

   // counters and syncs, undelayed
   raster_t raster;
   pixel_u  pixel_word;

   xvga_timing timing_gen (
      .clock  (clock),
      .rst_n  (rst_n),
      .raster (raster)
   );

   // two-cycle pipe from counter to display
   graphics gfx (
      .clock       (clock),
      .rst_n       (rst_n),
      .raster      (raster),
      .players     (players),
      .num_players (num_players),
      .mode        (mode),
      .object_grid (object_grid),
      .pixel       (pixel_word),
      .hsync       (hsync),
      .vsync       (vsync),
      .blank       (blank)
   );

   // display takes the flat 12-bit word
   assign pixel = pixel_word.raw;

endmodule

/* hw/grid_renderer.sv */
`include "graphics_macros.svh"

module grid_renderer (
   input  logic                   clock,
   input  logic                   rst_n,
   input  video_pkg::raster_t     raster,
   input  game_pkg::object_grid_t object_grid,
   output video_pkg::pixel_u      pixel
);
   import game_pkg::*;
   import video_pkg::*;

   localparam int TILE_SHIFT = $clog2(`TILE_SIZE);
   localparam int COL_W      = $clog2(`GRID_COLS);
   localparam int ROW_W      = $clog2(`GRID_ROWS);

   // grid rectangle, right and bottom edges exclusive
   localparam logic [10:0] X0 = 11'(`GRID_X0);
   localparam logic [9:0]  Y0 = 10'(`GRID_Y0);
   localparam logic [10:0] X1 = 11'(`GRID_X0 + `GRID_COLS * `TILE_SIZE);
   localparam logic [9:0]  Y1 = 10'(`GRID_Y0 + `GRID_ROWS * `TILE_SIZE);
   localparam logic [ROW_W-1:0] ROWS = ROW_W'(`GRID_ROWS);

   logic [10:0]      x_off;
   logic [9:0]       y_off;
   logic             in_grid;
   logic [COL_W-1:0] col;
   logic [ROW_W-1:0] row;
   grid_obj_t        obj;
   pixel_u           tile_color;
   pixel_u           pixel_next;

   always_comb begin
      x_off = raster.hcount - X0;
      y_off = raster.vcount - Y0;
      in_grid = (raster.hcount >= X0) && (raster.hcount < X1) &&
                (raster.vcount >= Y0) && (raster.vcount < Y1);
      // tile index is the offset divided by the tile size
      col = x_off[TILE_SHIFT +: COL_W];
      row = y_off[TILE_SHIFT +: ROW_W];
      obj = in_grid ? object_grid[col][row] : OBJ_EMPTY;

      case (obj)
         OBJ_EMPTY:         tile_color = OBJ_COLOR_EMPTY;
         OBJ_ONION_WHOLE:   tile_color = OBJ_COLOR_ONION_WHOLE;
         OBJ_ONION_CHOPPED: tile_color = OBJ_COLOR_ONION_CHOPPED;
         OBJ_BOWL_EMPTY:    tile_color = OBJ_COLOR_BOWL_EMPTY;
         OBJ_BOWL_FULL:     tile_color = OBJ_COLOR_BOWL_FULL;
         OBJ_POT_EMPTY:     tile_color = OBJ_COLOR_POT_EMPTY;
         OBJ_POT_RAW:       tile_color = OBJ_COLOR_POT_RAW;
         OBJ_POT_COOKED:    tile_color = OBJ_COLOR_POT_COOKED;
         OBJ_POT_FIRE:      tile_color = OBJ_COLOR_POT_FIRE;
         OBJ_FIRE:          tile_color = OBJ_COLOR_FIRE;
         OBJ_EXTINGUISHER:  tile_color = OBJ_COLOR_EXTINGUISHER;
         // codes 11..15 draw nothing
         default:           tile_color = '0;
      endcase

      // floor colour only inside the grid, black around it
      pixel_next = in_grid ? tile_color : '0;
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         pixel <= '0;
      end else begin
         pixel <= pixel_next;
      end
   end

   // grid height must map onto rows 0..12 only
   a_row_range: assert property (@(posedge clock) disable iff (!rst_n)
      in_grid |-> (row < ROWS));

endmodule

/* hw/player_blob.sv */
`include "graphics_macros.svh"

module player_blob (
   input  logic               clock,
   input  logic               rst_n,
   input  video_pkg::raster_t raster,
   input  game_pkg::player_t  player,
   input  logic               enable,
   output video_pkg::pixel_u  pixel
);
   import game_pkg::*;
   import video_pkg::*;

   // box and marker bounds as offsets from the top-left corner
   localparam logic [10:0] BOX     = 11'(`BLOB_SIZE);
   localparam logic [10:0] MARK    = 11'(`MARKER_SIZE);
   localparam logic [10:0] MID_LO  = 11'((`BLOB_SIZE - `MARKER_SIZE) / 2);
   localparam logic [10:0] MID_HI  = 11'((`BLOB_SIZE + `MARKER_SIZE) / 2);
   localparam logic [10:0] FAR_LO  = 11'(`BLOB_SIZE - `MARKER_SIZE);

   logic [10:0] px;
   logic [10:0] py;
   logic [10:0] dx;
   logic [10:0] dy;
   logic        in_box;
   logic        mid_x;
   logic        mid_y;
   logic        in_marker;
   pixel_u      body_color;
   pixel_u      pixel_next;

   always_comb begin
      px = {2'b00, player.x};
      py = {2'b00, player.y};
      // offsets wrap when left of / above the box, caught by the >= checks
      dx = raster.hcount - px;
      dy = {1'b0, raster.vcount} - py;
      in_box = (raster.hcount >= px) && (dx < BOX) &&
               ({1'b0, raster.vcount} >= py) && (dy < BOX);
      mid_x = (dx >= MID_LO) && (dx < MID_HI);
      mid_y = (dy >= MID_LO) && (dy < MID_HI);

      // marker hugs the facing edge, centred along it
      case (player.direction)
         DIR_LEFT:  in_marker = (dx < MARK) && mid_y;
         DIR_RIGHT: in_marker = (dx >= FAR_LO) && mid_y;
         DIR_UP:    in_marker = (dy < MARK) && mid_x;
         DIR_DOWN:  in_marker = (dy >= FAR_LO) && mid_x;
         default:   in_marker = 1'b0;
      endcase

      case (player.state)
         ST_NOTHING:       body_color = STATE_COLOR_NOTHING;
         ST_CHOPPING:      body_color = STATE_COLOR_CHOPPING;
         ST_ONION_WHOLE:   body_color = STATE_COLOR_ONION_WHOLE;
         ST_ONION_CHOPPED: body_color = STATE_COLOR_ONION_CHOPPED;
         ST_POT_EMPTY:     body_color = STATE_COLOR_POT_EMPTY;
         ST_POT_SOUP:      body_color = STATE_COLOR_POT_SOUP;
         ST_BOWL_EMPTY:    body_color = STATE_COLOR_BOWL_EMPTY;
         ST_BOWL_FULL:     body_color = STATE_COLOR_BOWL_FULL;
         ST_EXT_OFF:       body_color = STATE_COLOR_EXT_OFF;
         ST_EXT_ON:        body_color = STATE_COLOR_EXT_ON;
         // unused codes fall back to the idle colour
         default:          body_color = STATE_COLOR_NOTHING;
      endcase

      if (!enable || !in_box) begin
         pixel_next = '0;
      end else if (in_marker) begin
         pixel_next = MARKER_COLOR;
      end else begin
         pixel_next = body_color;
      end
   end

   // one cycle from raster to sprite pixel
   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         pixel <= '0;
      end else begin
         pixel <= pixel_next;
      end
   end

endmodule

/* hw/video_pkg.sv */
package video_pkg;

   // one raster position plus its sync and blank levels
   typedef struct packed {
      logic [10:0] hcount;
      logic [9:0]  vcount;
      logic        hsync;
      logic        vsync;
      logic        blank;
   } raster_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   // same 12 bits, either whole word or per channel
   typedef union packed {
      logic [11:0] raw;
      rgb_t        rgb;
   } pixel_u;

   // sprite body colours, one per player state
   localparam pixel_u STATE_COLOR_NOTHING       = 12'h888;
   localparam pixel_u STATE_COLOR_CHOPPING      = 12'h8C8;
   localparam pixel_u STATE_COLOR_ONION_WHOLE   = 12'hC6C;
   localparam pixel_u STATE_COLOR_ONION_CHOPPED = 12'hE9E;
   localparam pixel_u STATE_COLOR_POT_EMPTY     = 12'h666;
   localparam pixel_u STATE_COLOR_POT_SOUP      = 12'h964;
   localparam pixel_u STATE_COLOR_BOWL_EMPTY    = 12'hDDD;
   localparam pixel_u STATE_COLOR_BOWL_FULL     = 12'hDA6;
   localparam pixel_u STATE_COLOR_EXT_OFF       = 12'hA22;
   localparam pixel_u STATE_COLOR_EXT_ON        = 12'hF44;

   // tile colours, one per grid object; empty floor is dim, not black
   localparam pixel_u OBJ_COLOR_EMPTY           = 12'h222;
   localparam pixel_u OBJ_COLOR_ONION_WHOLE     = 12'h838;
   localparam pixel_u OBJ_COLOR_ONION_CHOPPED   = 12'hA6A;
   localparam pixel_u OBJ_COLOR_BOWL_EMPTY      = 12'hBBB;
   localparam pixel_u OBJ_COLOR_BOWL_FULL       = 12'hB84;
   localparam pixel_u OBJ_COLOR_POT_EMPTY       = 12'h444;
   localparam pixel_u OBJ_COLOR_POT_RAW         = 12'h553;
   localparam pixel_u OBJ_COLOR_POT_COOKED      = 12'h752;
   localparam pixel_u OBJ_COLOR_POT_FIRE        = 12'hD40;
   localparam pixel_u OBJ_COLOR_FIRE            = 12'hF80;
   localparam pixel_u OBJ_COLOR_EXTINGUISHER    = 12'hC00;

   localparam pixel_u MARKER_COLOR              = 12'h111;
   localparam pixel_u WELCOME_COLOR             = 12'h137;

endpackage

/* hw/xvga_timing.sv */
`include "graphics_macros.svh"

module xvga_timing (
   input  logic               clock,
   input  logic               rst_n,
   output video_pkg::raster_t raster
);

   localparam logic [10:0] H_LAST  = 11'(`FRAME_H_TOTAL - 1);
   localparam logic [9:0]  V_LAST  = 10'(`FRAME_V_TOTAL - 1);
   localparam logic [10:0] H_TOTAL = 11'(`FRAME_H_TOTAL);

   logic [10:0] hcount;
   logic [9:0]  vcount;
   logic [10:0] hcount_next;
   logic [9:0]  vcount_next;
   logic        hsync;
   logic        vsync;
   logic        blank;
   logic        h_end;
   logic        v_end;

   // next position, so sync and blank can be registered alongside it
   always_comb begin
      h_end = (hcount == H_LAST);
      v_end = (vcount == V_LAST);
      hcount_next = h_end ? 11'd0 : hcount + 11'd1;
      if (h_end) begin
         vcount_next = v_end ? 10'd0 : vcount + 10'd1;
      end else begin
         vcount_next = vcount;
      end
   end

   always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         // position (0,0) is active and outside both sync windows
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= hcount_next;
         vcount <= vcount_next;
         // syncs active low inside their windows
         hsync  <= !((hcount_next >= 11'(`H_SYNC_START)) &&
                     (hcount_next < 11'(`H_SYNC_END)));
         vsync  <= !((vcount_next >= 10'(`V_SYNC_START)) &&
                     (vcount_next < 10'(`V_SYNC_END)));
         blank  <= (hcount_next >= 11'(`ACTIVE_W)) ||
                   (vcount_next >= 10'(`ACTIVE_H));
      end
   end

   always_comb begin
      raster.hcount = hcount;
      raster.vcount = vcount;
      raster.hsync  = hsync;
      raster.vsync  = vsync;
      raster.blank  = blank;
   end

   // wrap must happen at the frame total, never past it
   a_hcount_range: assert property (@(posedge clock) disable iff (!rst_n)
      hcount < H_TOTAL);

endmodule

/* sim/graphics_tb.sv */
`include "graphics_macros.svh"

module graphics_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import game_pkg::*;
   import video_pkg::*;

   localparam int FRAME_CYCLES   = `FRAME_H_TOTAL * `FRAME_V_TOTAL;
   // tests need under four frames so one frame is spare
   localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES;
   // first row/column of the marker along the facing edge
   localparam int MID            = (`BLOB_SIZE - `MARKER_SIZE) / 2;
   localparam pixel_u BLACK      = '0;
   // colour lookup by object code and by player state
   localparam logic [11:0] OBJ_TABLE [0:10] = '{OBJ_COLOR_EMPTY, OBJ_COLOR_ONION_WHOLE,
      OBJ_COLOR_ONION_CHOPPED, OBJ_COLOR_BOWL_EMPTY, OBJ_COLOR_BOWL_FULL, OBJ_COLOR_POT_EMPTY,
      OBJ_COLOR_POT_RAW, OBJ_COLOR_POT_COOKED, OBJ_COLOR_POT_FIRE, OBJ_COLOR_FIRE,
      OBJ_COLOR_EXTINGUISHER};
   localparam logic [11:0] STATE_TABLE [0:9] = '{STATE_COLOR_NOTHING, STATE_COLOR_CHOPPING,
      STATE_COLOR_ONION_WHOLE, STATE_COLOR_ONION_CHOPPED, STATE_COLOR_POT_EMPTY,
      STATE_COLOR_POT_SOUP, STATE_COLOR_BOWL_EMPTY, STATE_COLOR_BOWL_FULL, STATE_COLOR_EXT_OFF,
      STATE_COLOR_EXT_ON};

   logic          clock = 1'b0;
   logic          rst_n;
   player_t [3:0] players;
   logic [1:0]    num_players;
   game_mode_t    mode;
   object_grid_t  object_grid;
   logic [11:0]   pixel;
   logic          hsync;
   logic          vsync;
   logic          blank;

   int            cyc;
   int            run_cycles = 0;
   int            checks = 0;
   int            errors = 0;
   int unsigned   lcg_state = 99;

   graphics_top DUT (
      .clock       (clock),
      .rst_n       (rst_n),
      .players     (players),
      .num_players (num_players),
      .mode        (mode),
      .object_grid (object_grid),
      .pixel       (pixel),
      .hsync       (hsync),
      .vsync       (vsync),
      .blank       (blank)
   );

   always #50 clock = ~clock;

   // cycle 0 is the first cycle after release with the counter at (0,0)
   always @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
         cyc <= 0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   always @(posedge clock) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   // tile plus enabled sprites per channel clamped at 15
   function automatic pixel_u expected_pixel(int h, int v);
      pixel_u c;
      pixel_u res;
      int     r;
      int     g;
      int     b;
      int     dx;
      int     dy;
      logic   mark;
      if (h >= `ACTIVE_W || v >= `ACTIVE_H) begin
         return BLACK;
      end
      if (mode != MODE_PLAY) begin
         return WELCOME_COLOR;
      end
      c = BLACK;
      dx = h - `GRID_X0;
      dy = v - `GRID_Y0;
      if (dx >= 0 && dx < `GRID_COLS * `TILE_SIZE && dy >= 0 && dy < `GRID_ROWS * `TILE_SIZE) begin
         c = OBJ_TABLE[object_grid[3'(dx / `TILE_SIZE)][4'(dy / `TILE_SIZE)]];
      end
      r = int'(c.rgb.r);
      g = int'(c.rgb.g);
      b = int'(c.rgb.b);
      for (int i = 0; i < 4; i++) begin
         dx = h - int'(players[2'(i)].x);
         dy = v - int'(players[2'(i)].y);
         if (i <= int'(num_players) && dx >= 0 && dx < `BLOB_SIZE &&
             dy >= 0 && dy < `BLOB_SIZE) begin
            // marker square sits on the facing edge and is centred along it
            case (players[2'(i)].direction)
               DIR_LEFT:  mark = dx < `MARKER_SIZE && dy >= MID && dy < MID + `MARKER_SIZE;
               DIR_RIGHT: mark = dx >= `BLOB_SIZE - `MARKER_SIZE &&
                                 dy >= MID && dy < MID + `MARKER_SIZE;
               DIR_UP:    mark = dy < `MARKER_SIZE && dx >= MID && dx < MID + `MARKER_SIZE;
               default:   mark = dy >= `BLOB_SIZE - `MARKER_SIZE &&
                                 dx >= MID && dx < MID + `MARKER_SIZE;
            endcase
            c = mark ? MARKER_COLOR : STATE_TABLE[players[2'(i)].state];
            r = r + int'(c.rgb.r);
            g = g + int'(c.rgb.g);
            b = b + int'(c.rgb.b);
         end
      end
      res.rgb.r = (r > 15) ? 4'hF : 4'(r);
      res.rgb.g = (g > 15) ? 4'hF : 4'(g);
      res.rgb.b = (b > 15) ? 4'hF : 4'(b);
      return res;
   endfunction

   // pixel for (h,v) shows two cycles after the counter reaches it
   task automatic wait_for_position(int h, int v);
      int target;
      target = v * `FRAME_H_TOTAL + h + 2;
      while (target <= cyc) begin
         target = target + FRAME_CYCLES;
      end
      while (cyc < target) begin
         @(negedge clock);
      end
   endtask

   task automatic check_color(int h, int v, pixel_u want, string label);
      logic want_blank;
      logic want_hsync;
      logic want_vsync;
      want_blank = (h >= `ACTIVE_W) || (v >= `ACTIVE_H);
      want_hsync = !(h >= `H_SYNC_START && h < `H_SYNC_END);
      want_vsync = !(v >= `V_SYNC_START && v < `V_SYNC_END);
      wait_for_position(h, v);
      checks++;
      if (pixel !== want.raw) begin
         errors++;
         $display("Fail at %0t: %s at (%0d,%0d), pixel %h, expected %h",
                  $time, label, h, v, pixel, want.raw);
      end
      if ({blank, hsync, vsync} !== {want_blank, want_hsync, want_vsync}) begin
         errors++;
         $display("Fail at %0t: %s at (%0d,%0d), blank/hsync/vsync %b%b%b, expected %b%b%b",
                  $time, label, h, v, blank, hsync, vsync, want_blank, want_hsync, want_vsync);
      end
   endtask

   // inputs change just after a rising edge
   task automatic drive_slot();
      @(posedge clock);
      #1;
   endtask

   // one full cycle so new inputs reach the first pipe stage
   task automatic settle_inputs();
      @(posedge clock);
      @(negedge clock);
   endtask

   task automatic report_test(string name, int start_errors);
      $display("test %s done, %0d errors", name, errors - start_errors);
   endtask

   task automatic reset_and_sync();
      int start;
      start = errors;
      // pipe still holds reset values for two cycles
      for (int k = 0; k < 2; k++) begin
         @(negedge clock);
         checks++;
         if (blank !== 1'b1 || pixel !== 12'h000) begin
            errors++;
            $display("Fail at %0t: cycle %0d after reset, blank %b pixel %h, expected 1 000",
                     $time, cyc, blank, pixel);
         end
      end
      check_color(0, 0, expected_pixel(0, 0), "first pixel");
      // across the active edge and the whole hsync window of row 0
      for (int h = 1000; h < `FRAME_H_TOTAL; h++) begin
         check_color(h, 0, expected_pixel(h, 0), "row 0 sync");
      end
      report_test("reset and syncs", start);
   endtask

   task automatic grid_tiles();
      int start;
      int h;
      int v;
      start = errors;
      drive_slot();
      for (int c = 0; c < `GRID_COLS; c++) begin
         for (int r = 0; r < `GRID_ROWS; r++) begin
            object_grid[3'(c)][4'(r)] = grid_obj_t'(4'(lcg_next() % 11));
         end
      end
      settle_inputs();
      // cell centres in raster order
      for (int r = 0; r < `GRID_ROWS; r++) begin
         for (int c = 0; c < `GRID_COLS; c++) begin
            h = `GRID_X0 + c * `TILE_SIZE + `TILE_SIZE / 2;
            v = `GRID_Y0 + r * `TILE_SIZE + `TILE_SIZE / 2;
            check_color(h, v, OBJ_TABLE[object_grid[3'(c)][4'(r)]], "tile centre");
         end
      end
      check_color(700, 600, BLACK, "right of grid");
      check_color(50, 700, BLACK, "below grid");
      report_test("grid tiles", start);
   endtask

   task automatic sprite_and_marker();
      int     start;
      int     x;
      int     y;
      pixel_u body;
      start = errors;
      for (int d = 0; d < 4; d++) begin
         drive_slot();
         // off the grid so the box shows its own colour only
         x = 384 + int'(lcg_next() % 64);
         y = 20 + 100 * d + int'(lcg_next() % 16);
         players[0].x = 9'(x);
         players[0].y = 9'(y);
         players[0].direction = direction_t'(2'(d));
         players[0].state = player_state_t'(4'(lcg_next() % 10));
         settle_inputs();
         body = STATE_TABLE[players[0].state];
         check_color(x + 15, y + 1, (d == 2) ? MARKER_COLOR : body, "top edge");
         check_color(x + 1, y + 15, (d == 0) ? MARKER_COLOR : body, "left edge");
         check_color(x + 30, y + 15, (d == 1) ? MARKER_COLOR : body, "right edge");
         check_color(x + 16, y + 16, body, "box centre");
         check_color(x + 15, y + 30, (d == 3) ? MARKER_COLOR : body, "bottom edge");
         check_color(x + 32, y + 31, BLACK, "right of box");
      end
      report_test("sprite and marker", start);
   endtask

   task automatic player_count_and_mix();
      int start;
      start = errors;
      drive_slot();
      // floor tile under both boxes with the second box offset by 4
      object_grid[2][3] = OBJ_EMPTY;
      players[0] = '{x: 9'd176, y: 9'd208, direction: DIR_LEFT, state: ST_POT_EMPTY};
      players[1] = '{x: 9'd180, y: 9'd212, direction: DIR_RIGHT, state: ST_POT_SOUP};
      num_players = 2'd0;
      settle_inputs();
      check_color(192, 216, expected_pixel(192, 216), "one player on tile");
      check_color(209, 218, expected_pixel(209, 218), "second player hidden");
      drive_slot();
      num_players = 2'd1;
      settle_inputs();
      check_color(192, 230, expected_pixel(192, 230), "two players mixed");
      check_color(209, 232, expected_pixel(209, 232), "second player shown");
      report_test("player count and mixing", start);
   endtask

   task automatic welcome_screen();
      int start;
      start = errors;
      drive_slot();
      mode = MODE_WELCOME;
      settle_inputs();
      // second player box still covers this tile pixel
      check_color(200, 240, WELCOME_COLOR, "welcome over player");
      check_color(200, 250, WELCOME_COLOR, "welcome over grid");
      check_color(1100, 300, BLACK, "welcome h blank");
      check_color(10, 600, WELCOME_COLOR, "welcome left edge");
      check_color(1023, 767, WELCOME_COLOR, "welcome last active");
      check_color(500, 773, BLACK, "welcome vsync");
      check_color(500, 790, BLACK, "welcome v blank");
      report_test("welcome screen", start);
   endtask

   initial begin
      rst_n = 1'b0;
      num_players = 2'd0;
      mode = MODE_PLAY;
      object_grid = '0;
      players = '0;
      // player 0 is always drawn so park it clear of the grid
      players[0].x = 9'd480;
      players[0].y = 9'd480;
      repeat (10) @(posedge clock);
      #1;
      rst_n = 1'b1;
      reset_and_sync();
      grid_tiles();
      sprite_and_marker();
      player_count_and_mix();
      welcome_screen();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
